/* hw/mac_column.sv */
`timescale 1ns/1ps

module mac_column (
  input  logic                                 clk,
  input  logic                                 resetn,
  input  pe_pkg::mac_ctrl_t                    ctrl,
  input  pe_pkg::pixel_t [pe_pkg::ROWS-1:0]    pixels_in,
  input  pe_pkg::weight_t                      weight,
  output pe_pkg::pixel_t [pe_pkg::ROWS-1:0]    pixels_out,
  output pe_pkg::row_acc_t                     sums
);

  pe_pkg::pixel_t [pe_pkg::ROWS-1:0] pix_q;
  pe_pkg::weight_t                   weight_q;

  // pixel register, one step of the systolic chain
  // cleared so the history before the first beat reads as zero
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pix_q <= '0;
    end else if (ctrl.mul_en) begin
      pix_q <= pixels_in;
    end
  end

  // weight register, fresh every beat
  always_ff @(posedge clk) begin
    if (ctrl.mul_en) begin
      weight_q <= weight;
    end
  end

  // next column sees these pixels one beat later
  assign pixels_out = pix_q;

  for (genvar r = 0; r < pe_pkg::ROWS; r++) begin : g_row
    pe_pkg::pixel_t pix;
    pe_pkg::prod_t  prod;
    pe_pkg::prod_t  prod_dly;
    pe_pkg::acc_t   addend;
    pe_pkg::acc_t   acc_q;

    assign pix = pix_q[r];

    // signed multiply, full product width
    assign prod = pix * weight_q;

    // remaining multiplier stages
    pipe_delay #(
      .payload_t (pe_pkg::prod_t),
      .DEPTH     (pe_pkg::MUL_DELAY - 1)
    ) u_mul_pipe (
      .clk    (clk),
      .resetn (resetn),
      .en     (ctrl.mul_en),
      .in     (prod),
      .out    (prod_dly)
    );

    // first product of a group starts from zero
    assign addend = ctrl.bypass ? '0 : acc_q;

    // accumulator, product sign-extended to the word width
    always_ff @(posedge clk) begin
      if (ctrl.acc_en) begin
        acc_q <= addend + pe_pkg::acc_t'(prod_dly);
      end
    end

    assign sums[r] = acc_q;
  end

endmodule

/* hw/mac_decode.sv */
`timescale 1ns/1ps

module mac_decode (
  input  logic              clk,
  input  logic              resetn,
  input  logic              s_valid,
  input  logic              s_cin_last,
  output logic              s_ready,
  input  logic              empty,
  output pe_pkg::mac_ctrl_t ctrl,
  output logic              acc_valid,
  output logic              load
);

  // per-beat control record, travels alongside the products
  typedef struct packed {
    logic accept;
    logic last;
  } ctl_rec_t;

  logic     mul_en;
  logic     acc_en;
  logic     first_q;
  ctl_rec_t rec_in;
  ctl_rec_t rec_out;

  // stall
  // a finished group sits in the accumulators and the shifter is still busy
  // freezing here keeps that group intact until load
  assign mul_en  = !(acc_valid && !empty);
  assign s_ready = mul_en;

  // record of this cycle, accept only on a real handshake
  assign rec_in.accept = s_valid && s_ready;
  assign rec_in.last   = s_valid && s_ready && s_cin_last;

  // delay matches operand reg plus product pipe in every column
  pipe_delay #(
    .payload_t (ctl_rec_t),
    .DEPTH     (pe_pkg::MUL_DELAY)
  ) u_ctl_pipe (
    .clk    (clk),
    .resetn (resetn),
    .en     (mul_en),
    .in     (rec_in),
    .out    (rec_out)
  );

  // product at the pipe output belongs to an accepted beat
  assign acc_en = rec_out.accept && mul_en;

  // first product of a group
  // set after reset and after every group end, cleared by any other product
  always_ff @(posedge clk) begin
    if (!resetn) begin
      first_q <= 1'b1;
    end else if (acc_en) begin
      first_q <= rec_out.last;
    end
  end

  // finished group flag
  // set on the edge that sums the last product
  // a new single-beat group may finish on the load edge, so set wins
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc_valid <= 1'b0;
    end else if (acc_en && rec_out.last) begin
      acc_valid <= 1'b1;
    end else if (load) begin
      acc_valid <= 1'b0;
    end
  end

  // hand the sums over once the shifter has drained
  assign load = acc_valid && empty;

  // same control to every column
  assign ctrl.mul_en = mul_en;
  assign ctrl.acc_en = acc_en;
  assign ctrl.bypass = first_q;

endmodule

/* hw/out_shifter.sv */
`timescale 1ns/1ps

module out_shifter (
  input  logic                                   clk,
  input  logic                                   resetn,
  input  logic                                   load,
  input  pe_pkg::row_acc_t [pe_pkg::COLS-1:0]    sums,
  input  logic                                   m_ready,
  output logic                                   m_valid,
  output pe_pkg::out_beat_t                      m_beat,
  output logic                                   empty
);

  // column shift register, top slot drives the output
  pe_pkg::row_acc_t [pe_pkg::COLS-1:0] data_q;
  pe_pkg::beat_cnt_t                   left_q;
  logic                                take;

  // valid for as long as a group is held
  assign m_valid = !empty;

  // output handshake
  assign take = m_valid && m_ready;

  // load all columns at once
  // then move one column toward the top per accepted beat
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= sums;
    end else if (take) begin
      for (int c = pe_pkg::COLS - 1; c > 0; c--) begin
        data_q[c] <= data_q[c-1];
      end
    end
  end

  // beats left and the empty flag
  // load only comes while empty, so it never meets a shift
  always_ff @(posedge clk) begin
    if (!resetn) begin
      empty  <= 1'b1;
      left_q <= '0;
    end else if (load) begin
      empty  <= 1'b0;
      left_q <= pe_pkg::beat_cnt_t'(pe_pkg::COLS);
    end else if (take) begin
      left_q <= left_q - 1'b1;
      // beat with last is leaving
      if (left_q == pe_pkg::beat_cnt_t'(1)) begin
        empty <= 1'b1;
      end
    end
  end

  // last column of the array comes out first
  assign m_beat.data = data_q[pe_pkg::COLS-1];

  // final beat of the group
  assign m_beat.last = (left_q == pe_pkg::beat_cnt_t'(1));

endmodule

/* hw/pe_pkg.sv */
package pe_pkg;

  // array geometry
  // rows = output words per beat, cols = output beats per group
  localparam int ROWS = 4;
  localparam int COLS = 4;

  // operand and result widths
  localparam int X_BITS = 8;
  localparam int K_BITS = 8;
  localparam int M_BITS = X_BITS + K_BITS;
  localparam int Y_BITS = 24;

  // accepted beat to valid product, operand reg plus product pipe
  localparam int MUL_DELAY = 2;

  // counter width for beats left in the output shifter
  localparam int CNT_BITS = $clog2(COLS + 1);

  // element types, all signed
  typedef logic signed [X_BITS-1:0] pixel_t;
  typedef logic signed [K_BITS-1:0] weight_t;
  typedef logic signed [M_BITS-1:0] prod_t;
  typedef logic signed [Y_BITS-1:0] acc_t;

  // one column result, row 0 in the low word
  typedef acc_t [ROWS-1:0] row_acc_t;

  // beats left in the output shifter
  typedef logic [CNT_BITS-1:0] beat_cnt_t;

  // input beat
  // pixels feed column 0, weights[c] feeds column c
  // cin_last closes the accumulation group
  typedef struct packed {
    pixel_t [ROWS-1:0]  pixels;
    weight_t [COLS-1:0] weights;
    logic               cin_last;
  } beat_in_t;

  // decode to column control, same for every column
  // mul_en advances operand regs and product pipe
  // acc_en writes the accumulators
  // bypass makes the product replace the old sum
  typedef struct packed {
    logic mul_en;
    logic acc_en;
    logic bypass;
  } mac_ctrl_t;

  // output beat, one column of row words
  // last marks the final column of a group
  typedef struct packed {
    row_acc_t data;
    logic     last;
  } out_beat_t;

endpackage

/* hw/pipe_delay.sv */
`timescale 1ns/1ps

module pipe_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     resetn,
  input  logic     en,
  input  payload_t in,
  output payload_t out
);

  // chain of stages, stage 0 takes the input
  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else if (en) begin
      stage[0] <= in;
      // whole chain moves together, nothing moves when en is low
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out = stage[DEPTH-1];

endmodule

/* hw/proc_engine.sv */
`timescale 1ns/1ps

module proc_engine (
  input  logic              clk,
  input  logic              resetn,
  input  logic              s_valid,
  output logic              s_ready,
  input  pe_pkg::beat_in_t  s_beat,
  input  logic              m_ready,
  output logic              m_valid,
  output pe_pkg::out_beat_t m_beat
);

  pe_pkg::mac_ctrl_t ctrl;
  logic              acc_valid;
  logic              load;
  logic              empty;

  // pixel chain, slot c feeds column c
  pe_pkg::pixel_t [pe_pkg::COLS:0][pe_pkg::ROWS-1:0] pix_chain;

  // finished sums of every column
  pe_pkg::row_acc_t [pe_pkg::COLS-1:0] col_sums;

  mac_decode u_decode (
    .clk        (clk),
    .resetn     (resetn),
    .s_valid    (s_valid),
    .s_cin_last (s_beat.cin_last),
    .s_ready    (s_ready),
    .empty      (empty),
    .ctrl       (ctrl),
    .acc_valid  (acc_valid),
    .load       (load)
  );

  // column 0 takes the pixels of the incoming beat
  assign pix_chain[0] = s_beat.pixels;

  for (genvar c = 0; c < pe_pkg::COLS; c++) begin : g_col
    mac_column u_column (
      .clk        (clk),
      .resetn     (resetn),
      .ctrl       (ctrl),
      .pixels_in  (pix_chain[c]),
      .weight     (s_beat.weights[c]),
      .pixels_out (pix_chain[c+1]),
      .sums       (col_sums[c])
    );
  end

  out_shifter u_result (
    .clk     (clk),
    .resetn  (resetn),
    .load    (load),
    .sums    (col_sums),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_beat  (m_beat),
    .empty   (empty)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the proc_engine testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_proc_engine -f sim.f -o tb_proc_engine
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_proc_engine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** FAILED ***" "$LOG"; then
  exit 1
fi
exit 0

/* sim.f */
hw/pe_pkg.sv
hw/pipe_delay.sv
hw/mac_decode.sv
hw/mac_column.sv
hw/out_shifter.sv
hw/proc_engine.sv
verif/tb_clkgen.sv
verif/tb_proc_engine.sv

/* verif/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic resetn
);

  // free-running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset held low for a few rising edges, released on an edge
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

/* verif/tb_proc_engine.sv */
`timescale 1ns/1ps

module tb_proc_engine;

  localparam int CLK_PERIOD  = 40;
  // upper bound on beats over all tests
  // 3 + 10 + 12 + 10 groups of up to 6 beats
  localparam int TOTAL_BEATS = 85;
  localparam int TIMEOUT_NS  = TOTAL_BEATS * pe_pkg::COLS * 20 * CLK_PERIOD;

  logic              clk;
  logic              resetn;
  logic              s_valid;
  logic              s_ready;
  pe_pkg::beat_in_t  s_beat;
  logic              m_ready;
  logic              m_valid;
  pe_pkg::out_beat_t m_beat;

  int                errors;
  bit                drain_done;
  pe_pkg::beat_in_t  send_q[$];
  pe_pkg::out_beat_t exp_q[$];

  // pixel history of the current test and the open group sums of the model
  pe_pkg::pixel_t [pe_pkg::ROWS-1:0] hist[$];
  int grp [pe_pkg::COLS][pe_pkg::ROWS];

  tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) clkgen_i (
    .clk    (clk),
    .resetn (resetn)
  );

  proc_engine dut_i (
    .clk     (clk),
    .resetn  (resetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_beat  (s_beat),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_beat  (m_beat)
  );

  task automatic compare_word(input string name, input int idx, input int row,
                              input pe_pkg::acc_t exp, input pe_pkg::acc_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: beat %0d row %0d expected %0d, actual %0d",
               name, idx, row, exp, act);
    end
  endtask

  task automatic compare_last(input string name, input int idx,
                              input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: beat %0d last expected %b, actual %b", name, idx, exp, act);
    end
  endtask

  // clear model and queues
  // the DUT pixel chain has been flushed with zeros by then
  function automatic void start_model();
    hist.delete();
    send_q.delete();
    exp_q.delete();
    for (int c = 0; c < pe_pkg::COLS; c++) begin
      for (int r = 0; r < pe_pkg::ROWS; r++) begin
        grp[c][r] = 0;
      end
    end
  endfunction

  // queue one beat and update the expected results
  // column c multiplies the pixels of c beats earlier by its own weight
  function automatic void add_beat(input pe_pkg::pixel_t [pe_pkg::ROWS-1:0] pix,
                                   input pe_pkg::weight_t [pe_pkg::COLS-1:0] w,
                                   input logic last);
    pe_pkg::beat_in_t  b;
    pe_pkg::out_beat_t ob;
    int                t;
    int                px;
    b.pixels   = pix;
    b.weights  = w;
    b.cin_last = last;
    send_q.push_back(b);
    hist.push_back(pix);
    t = hist.size() - 1;
    for (int c = 0; c < pe_pkg::COLS; c++) begin
      for (int r = 0; r < pe_pkg::ROWS; r++) begin
        px = (t - c >= 0) ? int'(hist[t-c][r]) : 0;
        grp[c][r] += px * int'(w[c]);
      end
    end
    // closing the group releases the last column first
    if (last) begin
      for (int c = pe_pkg::COLS - 1; c >= 0; c--) begin
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          ob.data[r] = pe_pkg::acc_t'(grp[c][r]);
          grp[c][r] = 0;
        end
        ob.last = (c == 0);
        exp_q.push_back(ob);
      end
    end
  endfunction

  // beats go out back to back
  // s_valid stays high until the last one is taken
  task automatic send_stream();
    int i;
    i = 0;
    while (i < send_q.size()) begin
      @(posedge clk);
      s_valid <= 1'b1;
      s_beat  <= send_q[i];
      // handshake seen here completes on the next rising edge
      @(negedge clk);
      if (s_ready) begin
        i++;
      end
    end
    @(posedge clk);
    s_valid <= 1'b0;
    s_beat  <= '0;
  endtask

  task automatic collect_stream(input string name);
    pe_pkg::out_beat_t exp_b;
    int                idx;
    idx = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      if (m_valid && m_ready) begin
        exp_b = exp_q.pop_front();
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          compare_word(name, idx, r, exp_b.data[r], m_beat.data[r]);
        end
        compare_last(name, idx, exp_b.last, m_beat.last);
        idx++;
      end
    end
    drain_done = 1'b1;
  endtask

  // m_ready modes
  // mode 0 keeps it high
  // mode 1 holds it low for hold cycles
  // mode 2 toggles it at random until drained
  task automatic drive_ready(input string name, input int mode, input int hold);
    bit [31:0] rnd;
    bit        saw_stall;
    saw_stall = 1'b0;
    if (mode == 1) begin
      @(posedge clk);
      m_ready <= 1'b0;
      repeat (hold) begin
        @(negedge clk);
        if (!s_ready) begin
          saw_stall = 1'b1;
        end
      end
      if (!saw_stall) begin
        errors++;
        $display("%s: s_ready stayed high through %0d cycles of output back-pressure",
                 name, hold);
      end
    end else if (mode == 2) begin
      while (!drain_done) begin
        @(posedge clk);
        rnd = $urandom;
        m_ready <= rnd[0];
      end
    end
    @(posedge clk);
    m_ready <= 1'b1;
  endtask

  task automatic run_stream(input string name, input int mode, input int hold);
    drain_done = 1'b0;
    fork
      send_stream();
      collect_stream(name);
      drive_ready(name, mode, hold);
    join
    // idle cycles also shift zeros through the pixel chain
    repeat (pe_pkg::COLS + 4) @(posedge clk);
    @(negedge clk);
    if (m_valid) begin
      errors++;
      $display("%s: output still valid after all expected beats were taken", name);
    end
  endtask

  // extreme operand values
  function automatic int edge_val(input int i);
    case (i % 4)
      0: return -128;
      1: return 127;
      2: return -1;
      default: return 100;
    endcase
  endfunction

  task automatic check_after_reset();
    @(negedge clk);
    if (m_valid !== 1'b0) begin
      errors++;
      $display("[ERROR] reset: m_valid expected 0, actual %b", m_valid);
    end
    if (s_ready !== 1'b1) begin
      errors++;
      $display("[ERROR] reset: s_ready expected 1, actual %b", s_ready);
    end
  endtask

  task automatic single_beat_groups();
    pe_pkg::pixel_t [pe_pkg::ROWS-1:0]  pix;
    pe_pkg::weight_t [pe_pkg::COLS-1:0] w;
    start_model();
    for (int g = 0; g < 3; g++) begin
      for (int r = 0; r < pe_pkg::ROWS; r++) begin
        pix[r] = pe_pkg::pixel_t'(g * 4 + r + 1);
      end
      for (int c = 0; c < pe_pkg::COLS; c++) begin
        w[c] = pe_pkg::weight_t'(c - 2 + g * 3);
      end
      add_beat(pix, w, 1'b1);
    end
    run_stream("single_beat", 0, 0);
  endtask

  task automatic multi_beat_groups();
    pe_pkg::pixel_t [pe_pkg::ROWS-1:0]  pix;
    pe_pkg::weight_t [pe_pkg::COLS-1:0] w;
    int lens [3] = '{3, 5, 2};
    int k;
    start_model();
    k = 0;
    for (int g = 0; g < 3; g++) begin
      for (int b = 0; b < lens[g]; b++) begin
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          pix[r] = pe_pkg::pixel_t'(edge_val(k + r));
        end
        for (int c = 0; c < pe_pkg::COLS; c++) begin
          w[c] = pe_pkg::weight_t'(edge_val(k + 2 * c + 1));
        end
        add_beat(pix, w, b == lens[g] - 1);
        k++;
      end
    end
    run_stream("multi_beat", 0, 0);
  endtask

  task automatic output_backpressure();
    pe_pkg::pixel_t [pe_pkg::ROWS-1:0]  pix;
    pe_pkg::weight_t [pe_pkg::COLS-1:0] w;
    start_model();
    for (int k = 0; k < 12; k++) begin
      for (int r = 0; r < pe_pkg::ROWS; r++) begin
        pix[r] = pe_pkg::pixel_t'(17 * k - 11 * r);
      end
      for (int c = 0; c < pe_pkg::COLS; c++) begin
        w[c] = pe_pkg::weight_t'(3 * c - 5 + k);
      end
      add_beat(pix, w, k % 2 == 1);
    end
    run_stream("backpressure", 1, 80);
  endtask

  task automatic random_traffic();
    pe_pkg::pixel_t [pe_pkg::ROWS-1:0]  pix;
    pe_pkg::weight_t [pe_pkg::COLS-1:0] w;
    bit [31:0] rnd;
    int        len;
    start_model();
    for (int g = 0; g < 10; g++) begin
      rnd = $urandom;
      len = 1 + int'(rnd % 6);
      for (int b = 0; b < len; b++) begin
        for (int r = 0; r < pe_pkg::ROWS; r++) begin
          pix[r] = pe_pkg::pixel_t'($urandom);
        end
        for (int c = 0; c < pe_pkg::COLS; c++) begin
          w[c] = pe_pkg::weight_t'($urandom);
        end
        add_beat(pix, w, b == len - 1);
      end
    end
    run_stream("random", 2, 0);
  endtask

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b1;
    errors  = 0;
    drain_done = 1'b0;
    void'($urandom(71481));
    @(posedge resetn);
    check_after_reset();
    single_beat_groups();
    multi_beat_groups();
    output_backpressure();
    random_traffic();
    $display("run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
